// File: src/net_req_pkg.sv
//////////////////////////////
// Network request package
// Sizing constants and the request word shared by
// the write-request command path
//////////////////////////////

package net_req_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  // Byte length of a request or chunk
  localparam int LEN_BITS = 28;

  // Virtual address of the transfer
  localparam int VADDR_BITS = 48;

  // Process id
  localparam int PID_BITS = 6;

  // Virtual function id
  localparam int VFID_BITS = 4;

  // Destination index
  localparam int DEST_BITS = 4;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // Path MTU, largest chunk on the TCP stream
  localparam logic [LEN_BITS-1:0] PMTU_BYTES = LEN_BITS'(4096);

  // Entries in the request FIFO
  localparam int QUEUE_DEPTH = 8;

  //////////////////////////////
  // Request word
  //////////////////////////////

  typedef struct packed {
    // Opcode and path flags
    logic                  mode;
    logic                  rdma;
    logic                  remote;
    // Requester identity
    logic [PID_BITS-1:0]   pid;
    logic [VFID_BITS-1:0]  vfid;
    logic [DEST_BITS-1:0]  dest;
    // Last of a transfer
    logic                  last;
    // Active request
    logic                  actv;
    // Host side origin
    logic                  host;
    // Transfer size in bytes
    logic [LEN_BITS-1:0]   len;
    // Start address, not advanced per chunk
    logic [VADDR_BITS-1:0] vaddr;
  } req_t;

endpackage

// File: src/meta_reg.sv
//////////////////////////////
// Request register slice
// Two-entry skid register on a valid/ready link
//////////////////////////////

`timescale 1ns/1ps

module meta_reg (
  input  logic              aclk,
  input  logic              aresetn,

  input  logic              s_valid,
  output logic              s_ready,
  input  net_req_pkg::req_t s_data,

  output logic              m_valid,
  input  logic              m_ready,
  output net_req_pkg::req_t m_data
);

  // Output entry
  logic              out_valid;
  net_req_pkg::req_t out_data;

  // Skid entry, filled only while the output stalls
  logic              skid_valid;
  net_req_pkg::req_t skid_data;

  logic out_free;

  // Output register can load this cycle
  assign out_free = ~out_valid | m_ready;

  // Ready from a flop only
  assign s_ready = ~skid_valid;

  assign m_valid = out_valid;
  assign m_data  = out_data;

  // Control
  always_ff @(posedge aclk) begin
    if (aresetn == 1'b0) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Drain skid first, else take input directly
      if (skid_valid) begin
        out_valid  <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= s_valid;
      end
    end else if (s_valid && s_ready) begin
      // Output stalled, park the new word
      skid_valid <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge aclk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : s_data;
    end
    if (~out_free && s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

endmodule

// File: src/req_rr_arb.sv
//////////////////////////////
// Write request arbiter
// Round-robin merge of host and card queues
// into one registered request stream
//////////////////////////////

`timescale 1ns/1ps

module req_rr_arb (
  input  logic              aclk,
  input  logic              aresetn,

  // Host queue
  input  logic              host_valid,
  output logic              host_ready,
  input  net_req_pkg::req_t host_data,

  // Card queue
  input  logic              card_valid,
  output logic              card_ready,
  input  net_req_pkg::req_t card_data,

  // Merged stream
  output logic              m_valid,
  input  logic              m_ready,
  output net_req_pkg::req_t m_data
);

  // Output register
  logic              out_valid;
  net_req_pkg::req_t out_data;

  // High when host won last, so card goes first next
  logic prio_card;

  logic load;
  logic grant_host;
  logic grant_card;

  //////////////////////////////
  // Grant
  //////////////////////////////

  // Register empty or emptied this cycle
  assign load = ~out_valid | m_ready;

  // Host wins alone or when it holds priority
  assign grant_host = host_valid & (~card_valid | ~prio_card);
  assign grant_card = card_valid & ~grant_host;

  // Each side ready unless the other one is granted
  assign host_ready = load & ~grant_card;
  assign card_ready = load & ~grant_host;

  assign m_valid = out_valid;
  assign m_data  = out_data;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (aresetn == 1'b0) begin
      out_valid <= 1'b0;
      prio_card <= 1'b0;
    end else if (load) begin
      out_valid <= grant_host | grant_card;
      // Flip priority only on an actual grant
      if (grant_host | grant_card) begin
        prio_card <= grant_host;
      end
    end
  end

  // Host bit is forwarded as the source sent it
  always_ff @(posedge aclk) begin
    if (load && grant_host) begin
      out_data <= host_data;
    end else if (load && grant_card) begin
      out_data <= card_data;
    end
  end

endmodule

// File: src/req_queue.sv
//////////////////////////////
// Request FIFO
// Buffers merged write requests ahead
// of the chunking parser
//////////////////////////////

`timescale 1ns/1ps

module req_queue (
  input  logic              aclk,
  input  logic              aresetn,

  input  logic              s_valid,
  output logic              s_ready,
  input  net_req_pkg::req_t s_data,

  output logic              m_valid,
  input  logic              m_ready,
  output net_req_pkg::req_t m_data
);

  // Storage
  net_req_pkg::req_t mem [net_req_pkg::QUEUE_DEPTH];

  // Pointers and fill level
  logic [$clog2(net_req_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(net_req_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(net_req_pkg::QUEUE_DEPTH+1)-1:0] count;

  logic push;
  logic pop;

  // Full and empty from the count
  assign s_ready = int'(count) != net_req_pkg::QUEUE_DEPTH;
  assign m_valid = count != '0;

  // Head of queue straight from storage
  assign m_data = mem[rd_ptr];

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  //////////////////////////////
  // Pointer control
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (aresetn == 1'b0) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at depth
      if (push) begin
        if (int'(wr_ptr) == net_req_pkg::QUEUE_DEPTH - 1) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (int'(rd_ptr) == net_req_pkg::QUEUE_DEPTH - 1) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Level moves only on push xor pop
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

endmodule

// File: src/req_tcp_parser_wr.sv
//////////////////////////////
// TCP write request parser
// Cuts each write request into chunks of
// at most one path MTU
//////////////////////////////

`timescale 1ns/1ps

module req_tcp_parser_wr (
  input  logic              aclk,
  input  logic              aresetn,

  input  logic              s_valid,
  output logic              s_ready,
  input  net_req_pkg::req_t s_data,

  output logic              m_valid,
  input  logic              m_ready,
  output net_req_pkg::req_t m_data
);

  //////////////////////////////
  // State
  //////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PARSE_WRITE,
    ST_SEND_WRITE
  } state_t;

  state_t state_c, state_n;

  // Current request, len holds what is left to cut
  net_req_pkg::req_t req_c, req_n;

  // Chunk being sent
  logic                             plast_c, plast_n;
  logic [net_req_pkg::LEN_BITS-1:0] plen_c, plen_n;

  // FSM register
  always_ff @(posedge aclk) begin
    if (aresetn == 1'b0) begin
      state_c <= ST_IDLE;
    end else begin
      state_c <= state_n;
    end
  end

  // Request and chunk registers
  always_ff @(posedge aclk) begin
    req_c   <= req_n;
    plast_c <= plast_n;
    plen_c  <= plen_n;
  end

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_n = state_c;

    case (state_c)
      ST_IDLE:
        if (s_valid) begin
          state_n = ST_PARSE_WRITE;
        end

      ST_PARSE_WRITE:
        state_n = ST_SEND_WRITE;

      // Back to parse while bytes remain
      ST_SEND_WRITE:
        if (m_ready) begin
          state_n = (req_c.len != '0) ? ST_PARSE_WRITE : ST_IDLE;
        end

      default:
        state_n = ST_IDLE;
    endcase
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_comb begin
    req_n   = req_c;
    plast_n = plast_c;
    plen_n  = plen_c;

    s_ready = 1'b0;
    m_valid = 1'b0;

    // Remote active TCP write, address kept from the command
    m_data        = '0;
    m_data.mode   = 1'b0;
    m_data.rdma   = 1'b0;
    m_data.remote = 1'b1;
    m_data.pid    = req_c.pid;
    m_data.vfid   = req_c.vfid;
    m_data.dest   = req_c.dest;
    m_data.last   = plast_c;
    m_data.len    = plen_c;
    m_data.actv   = 1'b1;
    m_data.host   = req_c.host;
    m_data.vaddr  = req_c.vaddr;

    case (state_c)
      ST_IDLE: begin
        s_ready = 1'b1;
        if (s_valid) begin
          req_n = s_data;
        end
      end

      ST_PARSE_WRITE: begin
        // Full MTU chunk, more to follow
        if (req_c.len > net_req_pkg::PMTU_BYTES) begin
          req_n.len = req_c.len - net_req_pkg::PMTU_BYTES;
          plen_n    = net_req_pkg::PMTU_BYTES;
          plast_n   = 1'b0;
        end else begin
          // Final chunk inherits the command's last bit
          req_n.len = '0;
          plen_n    = req_c.len;
          plast_n   = req_c.last;
        end
      end

      ST_SEND_WRITE:
        m_valid = 1'b1;

      default: ;
    endcase
  end

endmodule

// File: src/tcp_wr_req_top.sv
//////////////////////////////
// TCP write request path
// Arbiter, FIFO, MTU parser and output slice
//////////////////////////////

`timescale 1ns/1ps

module tcp_wr_req_top (
  input  logic              aclk,
  input  logic              aresetn,

  // Host write commands
  input  logic              s_req_host_valid,
  output logic              s_req_host_ready,
  input  net_req_pkg::req_t s_req_host_data,

  // Card write commands
  input  logic              s_req_card_valid,
  output logic              s_req_card_ready,
  input  net_req_pkg::req_t s_req_card_data,

  // Parsed chunks
  output logic              m_req_valid,
  input  logic              m_req_ready,
  output net_req_pkg::req_t m_req_data
);

  // Arbiter to FIFO
  logic              arb_req_valid;
  logic              arb_req_ready;
  net_req_pkg::req_t arb_req_data;

  // FIFO to parser
  logic              queue_req_valid;
  logic              queue_req_ready;
  net_req_pkg::req_t queue_req_data;

  // Parser to output slice
  logic              parsed_req_valid;
  logic              parsed_req_ready;
  net_req_pkg::req_t parsed_req_data;

  req_rr_arb u_arb (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .host_valid (s_req_host_valid),
    .host_ready (s_req_host_ready),
    .host_data  (s_req_host_data),
    .card_valid (s_req_card_valid),
    .card_ready (s_req_card_ready),
    .card_data  (s_req_card_data),
    .m_valid    (arb_req_valid),
    .m_ready    (arb_req_ready),
    .m_data     (arb_req_data)
  );

  req_queue u_queue (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (arb_req_valid),
    .s_ready (arb_req_ready),
    .s_data  (arb_req_data),
    .m_valid (queue_req_valid),
    .m_ready (queue_req_ready),
    .m_data  (queue_req_data)
  );

  req_tcp_parser_wr u_parser (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (queue_req_valid),
    .s_ready (queue_req_ready),
    .s_data  (queue_req_data),
    .m_valid (parsed_req_valid),
    .m_ready (parsed_req_ready),
    .m_data  (parsed_req_data)
  );

  // Output slice
  meta_reg u_out_reg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (parsed_req_valid),
    .s_ready (parsed_req_ready),
    .s_data  (parsed_req_data),
    .m_valid (m_req_valid),
    .m_ready (m_req_ready),
    .m_data  (m_req_data)
  );

endmodule

// File: verif/tb_tcp_wr_req.sv
//////////////////////////////
// TCP write request testbench
// File-driven host and card commands, chunk model
// and checks on the output stream
//////////////////////////////

`timescale 1ns/1ps

module tb_tcp_wr_req;

  localparam int MAX_REQ = 64;
  localparam int NUM_PID = 2 ** net_req_pkg::PID_BITS;

  logic              aclk = 1'b0;
  logic              aresetn;
  logic              s_req_host_valid;
  logic              s_req_host_ready;
  net_req_pkg::req_t s_req_host_data;
  logic              s_req_card_valid;
  logic              s_req_card_ready;
  net_req_pkg::req_t s_req_card_data;
  logic              m_req_valid;
  logic              m_req_ready;
  net_req_pkg::req_t m_req_data;

  // Requests from the data file
  int                                 n_req = 0;
  int                                 total_chunks = 0;
  int                                 req_src     [MAX_REQ];
  logic [net_req_pkg::PID_BITS-1:0]   req_pid     [MAX_REQ];
  logic [net_req_pkg::VFID_BITS-1:0]  req_vfid    [MAX_REQ];
  logic [net_req_pkg::DEST_BITS-1:0]  req_dest    [MAX_REQ];
  logic                               req_host    [MAX_REQ];
  logic                               req_last    [MAX_REQ];
  logic [net_req_pkg::LEN_BITS-1:0]   req_len     [MAX_REQ];
  logic [net_req_pkg::VADDR_BITS-1:0] req_vaddr   [MAX_REQ];
  int                                 req_nchunks [MAX_REQ];

  // Per source submission order
  int src_list [2][MAX_REQ];
  int n_src    [2] = '{0, 0};

  // Model state
  int                               pid_idx  [NUM_PID];
  logic                             req_sent [MAX_REQ];
  logic                             req_done [MAX_REQ];
  logic [net_req_pkg::LEN_BITS-1:0] rem      [MAX_REQ];
  int                               seen     [MAX_REQ];
  int                               src_done [2] = '{0, 0};
  logic                             src_drained [2] = '{1'b0, 1'b0};
  int                               cur_req = -1;
  int                               n_done = 0;

  logic   stim_loaded = 1'b0;
  logic   reset_done = 1'b0;
  int     wd_cycles;
  integer seed = 32'h785b_f0dc;

  tcp_wr_req_top u_tcp_wr_req_top (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .s_req_host_valid (s_req_host_valid),
    .s_req_host_ready (s_req_host_ready),
    .s_req_host_data  (s_req_host_data),
    .s_req_card_valid (s_req_card_valid),
    .s_req_card_ready (s_req_card_ready),
    .s_req_card_data  (s_req_card_data),
    .m_req_valid      (m_req_valid),
    .m_req_ready      (m_req_ready),
    .m_req_data       (m_req_data)
  );

  // 40 ns clock
  always #20 aclk = ~aclk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] got);
    assert (exp === got) else begin
      fail_now($sformatf("Mismatch %s exp %0h got %0h", name, exp, got));
    end
  endtask

  // Command word as the requester sends it
  function automatic net_req_pkg::req_t make_req(input int r);
    net_req_pkg::req_t q;
    q       = '0;
    q.pid   = req_pid[r];
    q.vfid  = req_vfid[r];
    q.dest  = req_dest[r];
    q.last  = req_last[r];
    q.host  = req_host[r];
    q.len   = req_len[r];
    q.vaddr = req_vaddr[r];
    return q;
  endfunction

  // Hold each command until ready, sampled mid low phase
  task automatic drive_source(input int src);
    int   k;
    int   r;
    logic acc;
    for (k = 0; k < n_src[src]; k++) begin
      r = src_list[src][k];
      if (src == 0) begin
        s_req_host_valid = 1'b1;
        s_req_host_data  = make_req(r);
      end else begin
        s_req_card_valid = 1'b1;
        s_req_card_data  = make_req(r);
      end
      acc = 1'b0;
      while (!acc) begin
        #10;
        acc = (src == 0) ? s_req_host_ready : s_req_card_ready;
        @(negedge aclk);
      end
      req_sent[r] = 1'b1;
    end
    if (src == 0) begin
      s_req_host_valid = 1'b0;
    end else begin
      s_req_card_valid = 1'b0;
    end
    src_drained[src] = 1'b1;
  endtask

  //////////////////////////////
  // Chunk model
  //////////////////////////////

  task automatic check_chunk(input net_req_pkg::req_t c);
    int                               r;
    int                               src;
    int                               exp_r;
    logic [net_req_pkg::LEN_BITS-1:0] exp_len;
    logic                             final_c;
    r = pid_idx[c.pid];
    assert (r >= 0 && req_sent[r] && !req_done[r]) else begin
      fail_now($sformatf("Chunk with pid %0h matches no request in flight", c.pid));
    end
    src = req_src[r];
    // Chunks of one request back to back
    if (cur_req >= 0) begin
      check_value("m_req_data.pid", req_pid[cur_req], c.pid);
    end else begin
      // New request, next in its source's order
      exp_r = src_list[src][src_done[src]];
      check_value("m_req_data.pid", req_pid[exp_r], c.pid);
    end
    // Copied and fixed fields
    check_value("m_req_data.vfid", req_vfid[r], c.vfid);
    check_value("m_req_data.dest", req_dest[r], c.dest);
    check_value("m_req_data.host", req_host[r], c.host);
    check_value("m_req_data.vaddr", req_vaddr[r], c.vaddr);
    check_value("m_req_data.mode", 0, c.mode);
    check_value("m_req_data.rdma", 0, c.rdma);
    check_value("m_req_data.remote", 1, c.remote);
    check_value("m_req_data.actv", 1, c.actv);
    // Full MTU until the remainder fits
    final_c = rem[r] <= net_req_pkg::PMTU_BYTES;
    exp_len = final_c ? rem[r] : net_req_pkg::PMTU_BYTES;
    check_value("m_req_data.len", exp_len, c.len);
    check_value("m_req_data.last", final_c & req_last[r], c.last);
    rem[r]  = rem[r] - exp_len;
    seen[r] = seen[r] + 1;
    if (final_c) begin
      check_value("chunk count", req_nchunks[r], seen[r]);
      req_done[r]   = 1'b1;
      src_done[src] = src_done[src] + 1;
      n_done        = n_done + 1;
      cur_req       = -1;
      // Round robin keeps both sources within one request
      if (src_done[0] < n_src[0] && src_done[1] < n_src[1]) begin
        assert (src_done[0] - src_done[1] <= 1 && src_done[1] - src_done[0] <= 1)
        else fail_now("One source fell behind the other by more than one request");
      end
    end else begin
      cur_req = r;
    end
  endtask

  //////////////////////////////
  // Processes
  //////////////////////////////

  initial begin : main
    integer               fd;
    integer               rc;
    integer               n;
    logic [63:0]          f_src, f_pid, f_vfid, f_dest, f_host, f_last;
    logic [63:0]          f_len, f_vaddr, f_chunks;
    logic [8*160-1:0]     line_buf;
    aresetn          = 1'b0;
    s_req_host_valid = 1'b0;
    s_req_host_data  = '0;
    s_req_card_valid = 1'b0;
    s_req_card_data  = '0;
    m_req_ready      = 1'b0;
    for (int i = 0; i < NUM_PID; i++) begin
      pid_idx[i] = -1;
    end
    fd = $fopen("verif/tcp_wr_testdata.txt", "r");
    assert (fd != 0) else fail_now("Cannot open the stimulus data file");
    while (!$feof(fd)) begin
      line_buf = '0;
      rc = $fgets(line_buf, fd);
      n  = 0;
      // Comment and blank lines give fewer fields
      if (rc != 0) begin
        n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h", f_src, f_pid, f_vfid,
                    f_dest, f_host, f_last, f_len, f_vaddr, f_chunks);
      end
      if (n == 9) begin
        assert (f_src < 2 && pid_idx[f_pid] < 0 && n_req < MAX_REQ)
        else fail_now("Bad source or repeated pid in the stimulus data file");
        req_src[n_req]     = f_src;
        req_pid[n_req]     = f_pid;
        req_vfid[n_req]    = f_vfid;
        req_dest[n_req]    = f_dest;
        req_host[n_req]    = f_host[0];
        req_last[n_req]    = f_last[0];
        req_len[n_req]     = f_len;
        req_vaddr[n_req]   = f_vaddr;
        req_nchunks[n_req] = f_chunks;
        rem[n_req]         = f_len;
        seen[n_req]        = 0;
        req_sent[n_req]    = 1'b0;
        req_done[n_req]    = 1'b0;
        pid_idx[f_pid]     = n_req;
        src_list[f_src][n_src[f_src]] = n_req;
        n_src[f_src]  = n_src[f_src] + 1;
        total_chunks  = total_chunks + f_chunks;
        n_req         = n_req + 1;
      end
    end
    $fclose(fd);
    assert (n_req > 0) else fail_now("No requests found in the stimulus data file");
    // Slack of 8 for random output stalls
    wd_cycles   = (total_chunks * 2 + n_req * 4 + 200) * 8;
    stim_loaded = 1'b1;
    repeat (8) @(negedge aclk);
    aresetn    = 1'b1;
    reset_done = 1'b1;
    wait (n_done == n_req && src_drained[0] && src_drained[1]);
    // Catch any extra chunk trailing the last one
    repeat (20) @(negedge aclk);
    assert (!m_req_valid)
    else fail_now("Output still valid after the last expected chunk");
    $display("test passed");
    $finish;
  end

  initial begin : host_driver
    wait (reset_done);
    @(negedge aclk);
    drive_source(0);
  end

  initial begin : card_driver
    wait (reset_done);
    @(negedge aclk);
    drive_source(1);
  end

  // Random output ready, sampling mid low phase
  initial begin : output_side
    logic              stall_prev;
    net_req_pkg::req_t held_data;
    stall_prev = 1'b0;
    held_data  = '0;
    wait (reset_done);
    forever begin
      @(negedge aclk);
      m_req_ready = ($random(seed) & 3) != 0;
      #10;
      // Stalled word must hold
      if (stall_prev) begin
        check_value("m_req_valid", 1, m_req_valid);
        check_value("m_req_data", held_data, m_req_data);
      end
      if (m_req_valid && m_req_ready) begin
        check_chunk(m_req_data);
      end
      stall_prev = m_req_valid & ~m_req_ready;
      held_data  = m_req_data;
    end
  end

  initial begin : watchdog
    wait (stim_loaded);
    repeat (wd_cycles) @(posedge aclk);
    fail_now("Timeout, expected chunks still missing when the watchdog ran out");
  end

endmodule

// File: flist.f
src/net_req_pkg.sv
src/meta_reg.sv
src/req_rr_arb.sv
src/req_queue.sv
src/req_tcp_parser_wr.sv
src/tcp_wr_req_top.sv
verif/tb_tcp_wr_req.sv

// File: verif/tcp_wr_testdata.txt
// Columns in hex: src(0 host, 1 card) pid vfid dest host last len vaddr chunks
// Chunk count is the expected number of path-MTU chunks for the request
// Host queue
0 01 1 2 1 1 00001000 000010000000 1
0 02 1 3 1 0 00001001 00001a2b3000 2
0 03 2 0 1 1 00000040 7fff00001234 1
0 04 3 1 1 1 00005800 000200004000 6
0 05 4 5 1 0 00003000 123456789abc 3
0 06 5 6 1 1 00000001 00000000ffff 1
0 07 6 7 1 1 00008000 0a0b0c0d0e0f 8
0 08 7 8 1 0 00000fff 400000000000 1
0 09 8 9 1 1 00002001 000000002000 3
0 0a 9 a 1 1 00009000 00c0ffee0000 9
0 0b a b 1 0 00000800 00000badf00d 1
0 0c b c 1 1 00004000 fedcba987654 4
0 0d c d 1 1 00001fff 000077770000 2
// Card queue
1 21 0 1 0 1 00000100 100000000000 1
1 22 1 2 0 1 00007001 00000000a000 8
1 23 2 3 0 0 00001000 0000deadbeef 1
1 24 3 4 0 1 00001001 555555555555 2
1 25 4 5 0 1 00006fff 000000100000 7
1 26 5 6 0 0 00000010 aaaaaaaaaaaa 1
1 27 6 7 0 1 00008001 0000f000f000 9
1 28 7 8 0 1 00002000 00000000beef 2
1 29 8 9 0 0 00005000 313233343536 5
1 2a 9 a 0 1 00000003 000000000001 1
1 2b a b 0 1 00003001 0f0f0f0f0f0f 4
1 2c b c 0 0 00001800 00abcdef0000 2
1 2d c d 0 1 00000fff 7ffffffff000 1
